/* Bender.yml */
package:
  name: leaf_overlay

sources:
  - rtl/leaf_pkg.sv
  - rtl/route_cfg_if.sv
  - rtl/leaf_ingress.sv
  - rtl/leaf_user_kernel.sv
  - rtl/leaf_egress.sv
  - rtl/leaf_top.sv
  - target: test
    files:
      - testbench/leaf_assertions.sv
      - testbench/leaf_checker.sv
      - testbench/tb_leaf_top.sv

/* filelist.f */
rtl/leaf_pkg.sv
rtl/route_cfg_if.sv
rtl/leaf_ingress.sv
rtl/leaf_user_kernel.sv
rtl/leaf_egress.sv
rtl/leaf_top.sv
testbench/leaf_assertions.sv
testbench/leaf_checker.sv
testbench/tb_leaf_top.sv

/* rtl/leaf_egress.sv */
`timescale 1ns/1ps

module leaf_egress (
    input  logic                                                           clk,
    input  logic                                                           reset,
    input  logic                                                           resend,
    route_cfg_if.sink                                                      cfg,
    input  logic [leaf_pkg::num_out_ports-1:0][leaf_pkg::payload_bits-1:0] user_data,
    input  logic [leaf_pkg::num_out_ports-1:0]                             user_vld,
    output logic [leaf_pkg::num_out_ports-1:0]                             user_ack,
    output leaf_pkg::leaf_packet_t                                         dout
);

    logic [leaf_pkg::leaf_bits-1:0]    route_leaf [leaf_pkg::num_out_ports];
    logic [leaf_pkg::port_bits-1:0]    route_port [leaf_pkg::num_out_ports];
    logic [leaf_pkg::addr_bits-1:0]    seq        [leaf_pkg::num_out_ports];
    logic [leaf_pkg::out_sel_bits-1:0] last;
    logic [leaf_pkg::out_sel_bits-1:0] sel;
    logic                              grant;
    leaf_pkg::leaf_packet_t            pkt;

    // Round robin search, starting just after the last port served.
    always_comb begin
        logic [leaf_pkg::out_sel_bits-1:0] idx;
        sel   = last;
        grant = 1'b0;
        idx   = last;
        for (int k = 0; k < leaf_pkg::num_out_ports; k++) begin
            idx = (idx == leaf_pkg::num_out_ports - 1) ? '0 : idx + 1'b1;
            if (!grant && !resend && user_vld[idx]) begin
                grant = 1'b1;
                sel   = idx;
            end
        end
    end

    always_comb begin
        user_ack = '0;
        if (grant) begin
            user_ack[sel] = 1'b1;
        end
    end

    always_comb begin
        pkt                     = '0;
        pkt.data_view.valid     = 1'b1;
        pkt.data_view.dest_leaf = route_leaf[sel];
        pkt.data_view.dest_port = route_port[sel];
        pkt.data_view.addr      = seq[sel];
        pkt.data_view.payload   = user_data[sel];
    end

    // Table entry index is the output number minus one.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < leaf_pkg::num_out_ports; i++) begin
                route_leaf[i] <= '0;
                route_port[i] <= '0;
            end
        end else if (cfg.we && (cfg.out_port >= 1) &&
                     (cfg.out_port <= leaf_pkg::num_out_ports)) begin
            route_leaf[cfg.out_port - 1] <= cfg.dest_leaf;
            route_port[cfg.out_port - 1] <= cfg.dest_port;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dout <= '0;
            last <= leaf_pkg::out_sel_bits'(leaf_pkg::num_out_ports - 1);
            for (int i = 0; i < leaf_pkg::num_out_ports; i++) begin
                seq[i] <= '0;
            end
        end else begin
            if (grant) begin
                dout      <= pkt;
                seq[sel]  <= seq[sel] + 1'b1;
                last      <= sel;
            end else begin
                dout <= '0;
            end
        end
    end

endmodule

/* rtl/leaf_ingress.sv */
`timescale 1ns/1ps

module leaf_ingress (
    input  logic                                                          clk,
    input  logic                                                          reset,
    input  leaf_pkg::leaf_packet_t                                        din,
    route_cfg_if.source                                                   cfg,
    output logic [leaf_pkg::num_in_ports-1:0][leaf_pkg::payload_bits-1:0] user_data,
    output logic [leaf_pkg::num_in_ports-1:0]                             user_vld,
    input  logic [leaf_pkg::num_in_ports-1:0]                             user_ack
);

    leaf_pkg::leaf_packet_t            din_q;
    logic                              is_cfg;
    logic [leaf_pkg::num_in_ports-1:0] push;
    logic [leaf_pkg::num_in_ports-1:0] pop;

    // Network input has no handshake, so capture every cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            din_q <= '0;
        end else begin
            din_q <= din;
        end
    end

    assign is_cfg = din_q.cfg_view.valid &&
                    (din_q.cfg_view.dest_port == leaf_pkg::cfg_port);

    // Routing command becomes a single table write.
    assign cfg.we        = is_cfg;
    assign cfg.out_port  = din_q.cfg_view.own_port;
    assign cfg.dest_leaf = din_q.cfg_view.target_leaf;
    assign cfg.dest_port = din_q.cfg_view.target_port;

    // One circular queue per user input port; port p+1 feeds queue p.
    for (genvar p = 0; p < leaf_pkg::num_in_ports; p++) begin : g_queue
        logic [leaf_pkg::payload_bits-1:0] mem [leaf_pkg::in_fifo_depth];
        logic [leaf_pkg::in_ptr_bits-1:0]  wr_ptr;
        logic [leaf_pkg::in_ptr_bits-1:0]  rd_ptr;
        logic [leaf_pkg::in_ptr_bits:0]    count;

        // Full queue drops the word.
        assign push[p] = din_q.data_view.valid &&
                         (din_q.data_view.dest_port == p + 1) &&
                         (count != leaf_pkg::in_fifo_depth);
        assign pop[p]  = user_vld[p] && user_ack[p];

        // Head word is visible as soon as it lands.
        assign user_vld[p]  = (count != '0);
        assign user_data[p] = mem[rd_ptr];

        always_ff @(posedge clk) begin
            if (push[p]) begin
                mem[wr_ptr] <= din_q.data_view.payload;
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push[p]) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop[p]) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                case ({push[p], pop[p]})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

endmodule

/* rtl/leaf_pkg.sv */
package leaf_pkg;

    // Network packet geometry.
    localparam int packet_bits  = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits    = 5;
    localparam int port_bits    = 4;
    localparam int addr_bits    = 7;

    // User side port counts and queue sizing.
    localparam int num_in_ports  = 2;
    localparam int num_out_ports = 3;
    localparam int in_fifo_depth = 4;
    localparam int in_ptr_bits   = $clog2(in_fifo_depth);
    localparam int out_sel_bits  = $clog2(num_out_ports);

    // Destination port reserved for routing commands.
    localparam int cfg_port = 0;

    localparam int cfg_reserved_bits = payload_bits - 2 * port_bits - leaf_bits;

    typedef struct packed {
        logic                    valid;
        logic [leaf_bits-1:0]    dest_leaf;
        logic [port_bits-1:0]    dest_port;
        logic [addr_bits-1:0]    addr;
        logic [payload_bits-1:0] payload;
    } data_packet_t;

    // Own port is the local output, numbered 1 to 3.
    typedef struct packed {
        logic                         valid;
        logic [leaf_bits-1:0]         dest_leaf;
        logic [port_bits-1:0]         dest_port;
        logic [addr_bits-1:0]         addr;
        logic [cfg_reserved_bits-1:0] reserved;
        logic [port_bits-1:0]         target_port;
        logic [leaf_bits-1:0]         target_leaf;
        logic [port_bits-1:0]         own_port;
    } cfg_packet_t;

    typedef union packed {
        data_packet_t data_view;
        cfg_packet_t  cfg_view;
    } leaf_packet_t;

endpackage

/* rtl/leaf_top.sv */
`timescale 1ns/1ps

module leaf_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             resend,
    input  logic [leaf_pkg::packet_bits-1:0] din,
    output logic [leaf_pkg::packet_bits-1:0] dout
);

    logic [leaf_pkg::num_in_ports-1:0][leaf_pkg::payload_bits-1:0]  in_data;
    logic [leaf_pkg::num_in_ports-1:0]                              in_vld;
    logic [leaf_pkg::num_in_ports-1:0]                              in_ack;
    logic [leaf_pkg::num_out_ports-1:0][leaf_pkg::payload_bits-1:0] out_data;
    logic [leaf_pkg::num_out_ports-1:0]                             out_vld;
    logic [leaf_pkg::num_out_ports-1:0]                             out_ack;

    route_cfg_if cfg_bus ();

    leaf_ingress ingress_inst (
        .clk       (clk),
        .reset     (reset),
        .din       (din),
        .cfg       (cfg_bus),
        .user_data (in_data),
        .user_vld  (in_vld),
        .user_ack  (in_ack)
    );

    leaf_user_kernel kernel_inst (
        .clk      (clk),
        .reset    (reset),
        .in_data  (in_data),
        .in_vld   (in_vld),
        .in_ack   (in_ack),
        .out_data (out_data),
        .out_vld  (out_vld),
        .out_ack  (out_ack)
    );

    leaf_egress egress_inst (
        .clk       (clk),
        .reset     (reset),
        .resend    (resend),
        .cfg       (cfg_bus),
        .user_data (out_data),
        .user_vld  (out_vld),
        .user_ack  (out_ack),
        .dout      (dout)
    );

endmodule

/* rtl/leaf_user_kernel.sv */
`timescale 1ns/1ps

module leaf_user_kernel (
    input  logic                                                           clk,
    input  logic                                                           reset,
    input  logic [leaf_pkg::num_in_ports-1:0][leaf_pkg::payload_bits-1:0]  in_data,
    input  logic [leaf_pkg::num_in_ports-1:0]                              in_vld,
    output logic [leaf_pkg::num_in_ports-1:0]                              in_ack,
    output logic [leaf_pkg::num_out_ports-1:0][leaf_pkg::payload_bits-1:0] out_data,
    output logic [leaf_pkg::num_out_ports-1:0]                             out_vld,
    input  logic [leaf_pkg::num_out_ports-1:0]                             out_ack
);

    logic                                                           take;
    logic [leaf_pkg::num_out_ports-1:0][leaf_pkg::payload_bits-1:0] result;

    // Both inputs consumed together, only into empty slots.
    assign take   = (&in_vld) && (out_vld == '0);
    assign in_ack = {leaf_pkg::num_in_ports{take}};

    // Sum, difference and xor of the pair.
    always_comb begin
        result[0] = in_data[0] + in_data[1];
        result[1] = in_data[0] - in_data[1];
        result[2] = in_data[0] ^ in_data[1];
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= result;
        end
    end

    // Each slot drains on its own ack.
    always_ff @(posedge clk) begin
        if (reset) begin
            out_vld <= '0;
        end else if (take) begin
            out_vld <= '1;
        end else begin
            out_vld <= out_vld & ~out_ack;
        end
    end

endmodule

/* rtl/route_cfg_if.sv */
`timescale 1ns/1ps

interface route_cfg_if;

    logic                           we;
    logic [leaf_pkg::port_bits-1:0] out_port;
    logic [leaf_pkg::leaf_bits-1:0] dest_leaf;
    logic [leaf_pkg::port_bits-1:0] dest_port;

    modport source (
        output we,
        output out_port,
        output dest_leaf,
        output dest_port
    );

    modport sink (
        input we,
        input out_port,
        input dest_leaf,
        input dest_port
    );

endinterface

/* testbench/leaf_assertions.sv */
`timescale 1ns/1ps

module leaf_assertions (
    input logic                             clk,
    input logic                             reset,
    input logic                             resend,
    input logic [leaf_pkg::packet_bits-1:0] dout
);

    int fail_count = 0;

    // Egress stays idle one cycle after a stall.
    stall_idle: assert property (@(posedge clk) disable iff (reset) resend |=> (dout == '0))
        else begin
            $error("dout carried a packet in the cycle after resend was high");
            fail_count++;
        end

    reset_idle: assert property (@(posedge clk) reset |=> (dout == '0))
        else begin
            $error("dout carried a packet in the cycle after reset");
            fail_count++;
        end

    valid_set: assert property (@(posedge clk) disable iff (reset)
                                (dout != '0) |-> dout[leaf_pkg::packet_bits-1])
        else begin
            $error("dout is not zero but its valid bit is low");
            fail_count++;
        end

endmodule

/* testbench/leaf_checker.sv */
`timescale 1ns/1ps

module leaf_checker (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             resend,
    input  logic [leaf_pkg::packet_bits-1:0] din,
    input  logic [leaf_pkg::packet_bits-1:0] dout,
    output int                               errors,
    output int                               checked,
    output int                               pending
);

    logic [leaf_pkg::leaf_bits-1:0]    route_leaf [leaf_pkg::num_out_ports];
    logic [leaf_pkg::port_bits-1:0]    route_port [leaf_pkg::num_out_ports];
    logic [leaf_pkg::addr_bits-1:0]    next_seq   [leaf_pkg::num_out_ports];
    logic [leaf_pkg::payload_bits-1:0] in_q       [leaf_pkg::num_in_ports][$];
    logic [leaf_pkg::payload_bits-1:0] exp_q      [leaf_pkg::num_out_ports][$];
    logic                              resend_q;

    // Reference model of the user kernel.
    function automatic logic [31:0] kernel_result(input logic [31:0] a, input logic [31:0] b,
                                                  input int out_idx);
        case (out_idx)
            0:       return a + b;
            1:       return a - b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic compare_value(input string name, input int out_idx,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s (output %0d): expected %h, got %h",
                     name, out_idx + 1, expected, actual);
        end
    endtask

    task automatic observe_input(input leaf_pkg::leaf_packet_t pkt);
        int          own;
        logic [31:0] a;
        logic [31:0] b;
        own = pkt.cfg_view.own_port;
        if (pkt.data_view.valid && pkt.cfg_view.dest_port == leaf_pkg::cfg_port) begin
            if (own >= 1 && own <= leaf_pkg::num_out_ports) begin
                route_leaf[own - 1] = pkt.cfg_view.target_leaf;
                route_port[own - 1] = pkt.cfg_view.target_port;
            end
        end else if (pkt.data_view.valid &&
                     (pkt.data_view.dest_port == 1 || pkt.data_view.dest_port == 2)) begin
            in_q[pkt.data_view.dest_port - 1].push_back(pkt.data_view.payload);
        end
        // Pairs form in arrival order.
        while (in_q[0].size() > 0 && in_q[1].size() > 0) begin
            a = in_q[0].pop_front();
            b = in_q[1].pop_front();
            for (int i = 0; i < leaf_pkg::num_out_ports; i++) begin
                exp_q[i].push_back(kernel_result(a, b, i));
            end
            pending += leaf_pkg::num_out_ports;
        end
    endtask

    task automatic check_output(input leaf_pkg::leaf_packet_t pkt);
        int out_idx;
        out_idx = -1;
        for (int i = 0; i < leaf_pkg::num_out_ports; i++) begin
            if (out_idx < 0 && route_port[i] == pkt.data_view.dest_port) begin
                out_idx = i;
            end
        end
        if (out_idx < 0) begin
            errors++;
            $display("Packet on dout has destination port %0d, which no output uses.",
                     pkt.data_view.dest_port);
        end else if (exp_q[out_idx].size() == 0) begin
            errors++;
            $display("Output %0d sent a packet that no input pair accounts for.", out_idx + 1);
        end else begin
            compare_value("dout.valid", out_idx, 32'd1, 32'(pkt.data_view.valid));
            compare_value("dout.dest_leaf", out_idx, 32'(route_leaf[out_idx]),
                          32'(pkt.data_view.dest_leaf));
            compare_value("dout.addr", out_idx, 32'(next_seq[out_idx]), 32'(pkt.data_view.addr));
            compare_value("dout.payload", out_idx, exp_q[out_idx].pop_front(),
                          pkt.data_view.payload);
            next_seq[out_idx] = next_seq[out_idx] + 1'b1;
            pending--;
            checked++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            errors   = 0;
            checked  = 0;
            pending  = 0;
            resend_q = 1'b0;
            for (int i = 0; i < leaf_pkg::num_out_ports; i++) begin
                route_leaf[i] = '0;
                route_port[i] = '0;
                next_seq[i]   = '0;
                exp_q[i].delete();
            end
            in_q[0].delete();
            in_q[1].delete();
        end else begin
            observe_input(din);
            if (resend_q && dout != '0) begin
                errors++;
                $display("A packet left the egress right after a cycle with resend high.");
            end
            if (dout != '0) begin
                check_output(dout);
            end
            resend_q = resend;
        end
    end

endmodule

/* testbench/tb_leaf_top.sv */
`timescale 1ns/1ps

module tb_leaf_top;

    localparam int batch_pairs    = leaf_pkg::in_fifo_depth;
    localparam int num_batches    = 40;
    localparam int num_pairs      = batch_pairs * num_batches;
    localparam int num_packets    = leaf_pkg::num_out_ports + 2 * num_pairs + num_batches + 4;
    localparam int timeout_cycles = num_packets * 40 + 200;

    logic                             clk;
    logic                             reset;
    logic                             resend;
    leaf_pkg::leaf_packet_t           din;
    logic [leaf_pkg::packet_bits-1:0] dout;
    int                               errors;
    int                               checked;
    int                               pending;
    logic [31:0]                      rng_state;

    leaf_top dut (
        .clk    (clk),
        .reset  (reset),
        .resend (resend),
        .din    (din),
        .dout   (dout)
    );

    leaf_checker check_inst (
        .clk     (clk),
        .reset   (reset),
        .resend  (resend),
        .din     (din),
        .dout    (dout),
        .errors  (errors),
        .checked (checked),
        .pending (pending)
    );

    bind leaf_top leaf_assertions assert_inst (
        .clk    (clk),
        .reset  (reset),
        .resend (resend),
        .dout   (dout)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:15];
    endfunction

    function automatic logic [31:0] random_word();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi, lo};
    endfunction

    // One packet for a cycle, then a short random gap.
    task automatic drive_packet(input leaf_pkg::leaf_packet_t pkt);
        int gap;
        din = pkt;
        @(negedge clk);
        din = '0;
        gap = next_random() % 3;
        repeat (gap) @(negedge clk);
    endtask

    task automatic send_route(input int own, input int leaf, input int port);
        leaf_pkg::leaf_packet_t pkt;
        pkt                      = '0;
        pkt.cfg_view.valid       = 1'b1;
        pkt.cfg_view.dest_leaf   = 5'd3;
        pkt.cfg_view.dest_port   = leaf_pkg::cfg_port;
        pkt.cfg_view.own_port    = leaf_pkg::port_bits'(own);
        pkt.cfg_view.target_leaf = leaf_pkg::leaf_bits'(leaf);
        pkt.cfg_view.target_port = leaf_pkg::port_bits'(port);
        drive_packet(pkt);
    endtask

    task automatic send_word(input int port, input logic [31:0] payload);
        leaf_pkg::leaf_packet_t pkt;
        pkt                    = '0;
        pkt.data_view.valid     = 1'b1;
        pkt.data_view.dest_leaf = 5'd3;
        pkt.data_view.dest_port = leaf_pkg::port_bits'(port);
        pkt.data_view.payload   = payload;
        drive_packet(pkt);
    endtask

    // Either valid low, or a destination port above 2.
    task automatic send_ignored();
        leaf_pkg::leaf_packet_t pkt;
        logic [31:0]            hi;
        logic [15:0]            lo;
        hi  = random_word();
        lo  = next_random();
        pkt = {1'b0, hi, lo};
        if (next_random() % 2 == 0) begin
            pkt.data_view.valid     = 1'b1;
            pkt.data_view.dest_port = leaf_pkg::port_bits'(3 + next_random() % 13);
        end
        drive_packet(pkt);
    endtask

    task automatic send_batch(input logic port1_first);
        logic [31:0] first_words  [batch_pairs];
        logic [31:0] second_words [batch_pairs];
        for (int k = 0; k < batch_pairs; k++) begin
            first_words[k]  = random_word();
            second_words[k] = random_word();
        end
        for (int k = 0; k < batch_pairs; k++) begin
            send_word(1, first_words[k]);
            if (!port1_first) begin
                send_word(2, second_words[k]);
            end
        end
        send_ignored();
        for (int k = 0; k < batch_pairs && port1_first; k++) begin
            send_word(2, second_words[k]);
        end
    endtask

    // Wait for every expected packet, with optional random stalls.
    task automatic drain_outputs(input logic stall);
        int stall_left;
        stall_left = 0;
        while (pending != 0) begin
            if (stall && stall_left == 0 && next_random() % 6 == 0) begin
                stall_left = 1 + next_random() % 8;
            end
            resend = (stall_left != 0);
            if (stall_left != 0) begin
                stall_left--;
            end
            @(negedge clk);
        end
        resend = 1'b0;
    endtask

    initial begin
        int local_errors;
        int total_errors;
        local_errors = 0;
        rng_state    = 32'd19172;
        reset        = 1'b1;
        resend       = 1'b0;
        din          = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) send_ignored();
        send_route(1, 7, 9);
        send_route(2, 12, 5);
        send_route(3, 21, 14);
        repeat (3) @(negedge clk);
        for (int b = 0; b < num_batches; b++) begin
            send_batch(next_random() % 2 == 0);
            drain_outputs(b % 2 == 1);
        end
        repeat (10) @(negedge clk);
        if (checked != leaf_pkg::num_out_ports * num_pairs) begin
            $display("Output packet count %0d differs from the expected %0d.",
                     checked, leaf_pkg::num_out_ports * num_pairs);
            local_errors++;
        end
        total_errors = errors + dut.assert_inst.fail_count + local_errors;
        $display("Report: %0d packets checked, %0d checker errors, %0d assertion failures, %0d other",
                 checked, errors, dut.assert_inst.fail_count, local_errors);
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule
